//--- Bender.yml
package:
  name: squeeze_conv_layer

sources:
  - design/squeeze_pkg.sv
  - design/mac_lane.sv
  - design/weight_rom.sv
  - design/output_requant.sv
  - design/window_sequencer.sv
  - design/squeeze_conv_layer.sv
  - target: simulation
    files:
      - dv/squeeze_conv_layer_tb.sv

//--- design/mac_lane.sv
`timescale 1ns/10ps
`default_nettype none

module mac_lane
	import squeeze_pkg::*;
(
	input  wire        clk,
	input  wire        rst_n,
	input  wire        acc_en,
	input  wire        acc_first,
	input  wire data_t tap,
	input  wire data_t weight,
	output acc_t       acc
);

	// Full-width signed product, both operands sign extended
	acc_t product;

	assign product = acc_t'(tap) * acc_t'(weight);

	////////////////////////////////////////////////////////////
	// Accumulator
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc <= '0;
		end else if (acc_first) begin
			// First tap of a window restarts the sum
			acc <= product;
		end else if (acc_en) begin
			acc <= acc + product;
		end
	end

	// First-tap strobe from the sequencer only comes with a live tap
	a_first_has_en: assert property (
		@(posedge clk) disable iff (!rst_n)
		acc_first |-> acc_en
	);

endmodule

`default_nettype wire

//--- design/output_requant.sv
`timescale 1ns/10ps
`default_nettype none

module output_requant
	import squeeze_pkg::*;
#(
	parameter int LANES = 4
)
(
	input  wire        clk,
	input  wire        rst_n,
	input  wire        window_done,
	input  wire acc_t  acc [LANES],
	output data_t      ofm [LANES]
);

	// Accumulator plus channel bias
	acc_t biased [LANES];

	always_comb begin
		for (int l = 0; l < LANES; l++) begin
			biased[l] = acc[l] + bias_value(l);
		end
	end

	////////////////////////////////////////////////////////////
	// ReLU and truncation, held until next window
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int l = 0; l < LANES; l++) begin
				ofm[l] <= '0;
			end
		end else if (window_done) begin
			for (int l = 0; l < LANES; l++) begin
				if (biased[l][acc_width-1]) begin
					// Negative clamps to zero
					ofm[l] <= '0;
				end else begin
					// Sign bit, then bits 28..14
					ofm[l] <= {biased[l][acc_width-1],
						biased[l][frac_bits+data_width-2:frac_bits]};
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- design/squeeze_conv_layer.sv
`timescale 1ns/10ps
`default_nettype none

module squeeze_conv_layer
	import squeeze_pkg::*;
#(
	parameter int LANES      = 4,
	parameter int CHIN       = 2,
	parameter int KERNEL_DIM = 3,
	parameter int WOUT       = 2
)
(
	input  wire        clk,
	input  wire        rst_n,
	input  wire        layer_en,
	input  wire data_t ifm,
	input  wire        ram_feedback,
	output data_t      ofm [LANES],
	output logic       ofm_sample,
	output logic       layer_finish
);

	localparam int ADDR_W = $clog2(KERNEL_DIM * KERNEL_DIM * CHIN);

	data_t             tap_q;
	data_t             tap_d;
	logic              en_q;
	logic [ADDR_W-1:0] tap_addr;
	logic              acc_en;
	logic              acc_first;
	logic              window_done;
	data_t             weights [LANES];
	acc_t              lane_acc [LANES];

	////////////////////////////////////////////////////////////
	// Input stage and ROM alignment
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			en_q <= 1'b0;
		end else begin
			en_q <= layer_en;
		end
	end

	// Tap waits one extra cycle for its weight
	always_ff @(posedge clk) begin
		tap_q <= ifm;
		tap_d <= tap_q;
	end

	window_sequencer #(
		.CHIN       (CHIN),
		.KERNEL_DIM (KERNEL_DIM),
		.WOUT       (WOUT)
	) u_seq (
		.clk          (clk),
		.rst_n        (rst_n),
		.en_q         (en_q),
		.ram_feedback (ram_feedback),
		.tap_addr     (tap_addr),
		.acc_en       (acc_en),
		.acc_first    (acc_first),
		.window_done  (window_done),
		.ofm_sample   (ofm_sample),
		.layer_finish (layer_finish)
	);

	weight_rom #(
		.LANES      (LANES),
		.CHIN       (CHIN),
		.KERNEL_DIM (KERNEL_DIM)
	) u_rom (
		.clk      (clk),
		.tap_addr (tap_addr),
		.weights  (weights)
	);

	////////////////////////////////////////////////////////////
	// One MAC per output channel
	////////////////////////////////////////////////////////////

	genvar l;
	generate
		for (l = 0; l < LANES; l++) begin : g_lane
			mac_lane u_mac (
				.clk       (clk),
				.rst_n     (rst_n),
				.acc_en    (acc_en),
				.acc_first (acc_first),
				.tap       (tap_d),
				.weight    (weights[l]),
				.acc       (lane_acc[l])
			);
		end
	endgenerate

	output_requant #(
		.LANES (LANES)
	) u_requant (
		.clk         (clk),
		.rst_n       (rst_n),
		.window_done (window_done),
		.acc         (lane_acc),
		.ofm         (ofm)
	);

endmodule

`default_nettype wire

//--- design/squeeze_pkg.sv
`default_nettype none

package squeeze_pkg;

	// Datapath word sizes
	localparam int data_width = 16;
	localparam int acc_width  = 32;
	// Binary point of the accumulator
	localparam int frac_bits  = 14;

	typedef logic signed [data_width-1:0] data_t;
	typedef logic signed [acc_width-1:0]  acc_t;

	// Small integer weight in -3..3, walks with tap address and lane
	function automatic data_t weight_value(input int addr, input int lane);
		int w;
		w = ((addr * 5 + lane * 3 + 2) % 7) - 3;
		return data_t'(w);
	endfunction

	// Per-channel bias in quarter steps, accumulator scale
	function automatic acc_t bias_value(input int lane);
		int b;
		b = (lane - 1) * (1 << (frac_bits - 2));
		return acc_t'(b);
	endfunction

endpackage

`default_nettype wire

//--- design/weight_rom.sv
`timescale 1ns/10ps
`default_nettype none

module weight_rom
	import squeeze_pkg::*;
#(
	parameter int LANES      = 4,
	parameter int CHIN       = 2,
	parameter int KERNEL_DIM = 3
)
(
	input  wire                                       clk,
	input  wire [$clog2(KERNEL_DIM*KERNEL_DIM*CHIN)-1:0] tap_addr,
	output data_t                                     weights [LANES]
);

	// Taps per kernel window
	localparam int WIN_LEN = KERNEL_DIM * KERNEL_DIM * CHIN;

	////////////////////////////////////////////////////////////
	// One ROM column per lane
	////////////////////////////////////////////////////////////

	genvar l;
	generate
		for (l = 0; l < LANES; l++) begin : g_lane
			data_t mem [WIN_LEN];

			// Contents fixed at elaboration
			initial begin
				for (int a = 0; a < WIN_LEN; a++) begin
					mem[a] = weight_value(a, l);
				end
			end

			// Registered read, one cycle latency
			always_ff @(posedge clk) begin
				weights[l] <= mem[tap_addr];
			end
		end
	endgenerate

endmodule

`default_nettype wire

//--- design/window_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module window_sequencer #(
	parameter int CHIN       = 2,
	parameter int KERNEL_DIM = 3,
	parameter int WOUT       = 2
)
(
	input  wire                                          clk,
	input  wire                                          rst_n,
	input  wire                                          en_q,
	input  wire                                          ram_feedback,
	output logic [$clog2(KERNEL_DIM*KERNEL_DIM*CHIN)-1:0] tap_addr,
	output logic                                         acc_en,
	output logic                                         acc_first,
	output logic                                         window_done,
	output logic                                         ofm_sample,
	output logic                                         layer_finish
);

	localparam int WIN_LEN   = KERNEL_DIM * KERNEL_DIM * CHIN;
	localparam int ADDR_W    = $clog2(WIN_LEN);
	localparam int WINDOWS   = WOUT * WOUT;
	localparam int WIN_CNT_W = $clog2(WINDOWS + 1);

	logic [WIN_CNT_W-1:0] win_cnt;
	logic                 taps_done;
	logic                 advance;
	logic                 at_last;
	logic                 last_al;
	logic                 done_q;
	logic                 layer_end;
	logic                 fb_seen;

	// All windows issued, stop taking taps
	assign taps_done = (win_cnt == WIN_CNT_W'(WINDOWS));
	assign advance   = en_q && !taps_done;
	assign at_last   = (tap_addr == ADDR_W'(WIN_LEN - 1));

	////////////////////////////////////////////////////////////
	// Tap address and issued window count
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tap_addr <= '0;
			win_cnt  <= '0;
		end else if (advance) begin
			// Wrap at window length
			if (at_last) begin
				tap_addr <= '0;
				win_cnt  <= win_cnt + 1'b1;
			end else begin
				tap_addr <= tap_addr + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Strobes, lined up with ROM output, then the tail
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc_en      <= 1'b0;
			acc_first   <= 1'b0;
			last_al     <= 1'b0;
			window_done <= 1'b0;
			done_q      <= 1'b0;
			ofm_sample  <= 1'b0;
		end else begin
			acc_en      <= advance;
			acc_first   <= advance && (tap_addr == '0);
			last_al     <= advance && at_last;
			// MAC holds full sum one cycle after last aligned tap
			window_done <= last_al;
			// Requant register loads on done, sample follows it
			done_q      <= window_done;
			ofm_sample  <= done_q;
		end
	end

	////////////////////////////////////////////////////////////
	// Layer end and finish handshake
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			layer_end <= 1'b0;
			fb_seen   <= 1'b0;
		end else begin
			// Only the last window's done arrives once all are issued
			if (window_done && taps_done) begin
				layer_end <= 1'b1;
			end
			if (ram_feedback) begin
				fb_seen <= 1'b1;
			end
		end
	end

	assign layer_finish = layer_end && !fb_seen;

	// No window completes once the layer is over
	a_no_done_after_end: assert property (
		@(posedge clk) disable iff (!rst_n)
		layer_end |-> !window_done
	);

	a_addr_in_window: assert property (
		@(posedge clk) disable iff (!rst_n)
		tap_addr < ADDR_W'(WIN_LEN)
	);

endmodule

`default_nettype wire

//--- dv/squeeze_conv_layer_tb.sv
`timescale 1ns/10ps
`default_nettype none

module squeeze_conv_layer_tb
	import squeeze_pkg::*;
();

	localparam int LANES      = 4;
	localparam int CHIN       = 2;
	localparam int KERNEL_DIM = 3;
	localparam int WOUT       = 2;
	localparam int WIN_LEN    = KERNEL_DIM * KERNEL_DIM * CHIN;
	localparam int WINDOWS    = WOUT * WOUT;
	// Room for one pause cycle per tap, plus reset and drain
	localparam int MAX_CYCLES = WINDOWS * WIN_LEN * 2 + 50;
	// Falling edge with the last tap to falling edge with the sample
	localparam int SAMPLE_LAT = 5;
	// Total pause cycles spread over the stream
	localparam int GAP_BUDGET = WINDOWS * WIN_LEN / 2;

	logic   clk;
	logic   rst_n;
	logic   layer_en;
	data_t  ifm;
	logic   ram_feedback;
	data_t  ofm [LANES];
	logic   ofm_sample;
	logic   layer_finish;

	integer seed;
	int     fd;
	int     cycle_cnt;
	int     sample_cnt;
	int     mismatch_cnt;
	int     other_cnt;
	int     gap_left;
	// Expected lanes per window, flattened
	data_t  exp_q [$];
	// Cycle of each window's last tap
	int     last_tap_q [$];

	squeeze_conv_layer #(
		.LANES      (LANES),
		.CHIN       (CHIN),
		.KERNEL_DIM (KERNEL_DIM),
		.WOUT       (WOUT)
	) u_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.layer_en     (layer_en),
		.ifm          (ifm),
		.ram_feedback (ram_feedback),
		.ofm          (ofm),
		.ofm_sample   (ofm_sample),
		.layer_finish (layer_finish)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Cycle count and run limit
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, layer never completed", cycle_cnt);
			other_cnt = other_cnt + 1;
			finish_run();
		end
	end

	task automatic finish_run();
		$display("checked %0d samples: %0d mismatches, %0d other errors",
			sample_cnt, mismatch_cnt, other_cnt);
		if (mismatch_cnt == 0 && other_cnt == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	endtask

	////////////////////////////////////////////////////////////
	// Output monitor, sampled mid-cycle
	////////////////////////////////////////////////////////////

	task automatic check_sample();
		data_t exp_val;
		int    lat;
		sample_cnt = sample_cnt + 1;
		if (sample_cnt > WINDOWS) begin
			$display("t=%0t ofm_sample pulse %0d is beyond the %0d windows of a layer",
				$time, sample_cnt, WINDOWS);
			other_cnt = other_cnt + 1;
		end else if (exp_q.size() < LANES || last_tap_q.size() == 0) begin
			$display("t=%0t ofm_sample pulse with no window sent for it", $time);
			other_cnt = other_cnt + 1;
		end else begin
			for (int l = 0; l < LANES; l++) begin
				exp_val = exp_q.pop_front();
				if (ofm[l] !== exp_val) begin
					$display("MISMATCH t=%0t ofm[%0d] got %h expected %h",
						$time, l, ofm[l], exp_val);
					mismatch_cnt = mismatch_cnt + 1;
				end
			end
			// Distance from the last tap of the same window
			lat = cycle_cnt - last_tap_q.pop_front();
			if (lat != SAMPLE_LAT) begin
				$display("MISMATCH t=%0t ofm_sample latency got %0d expected %0d",
					$time, lat, SAMPLE_LAT);
				mismatch_cnt = mismatch_cnt + 1;
			end
			// Finish rises with the last done, one cycle ahead of its sample
			if (sample_cnt == WINDOWS && !layer_finish) begin
				$display("t=%0t layer_finish not high at the last ofm_sample", $time);
				other_cnt = other_cnt + 1;
			end
		end
	endtask

	always @(negedge clk) begin
		if (!rst_n) begin
			if (ofm_sample || layer_finish) begin
				$display("t=%0t ofm_sample or layer_finish high during reset", $time);
				other_cnt = other_cnt + 1;
			end
		end else begin
			if (layer_finish && sample_cnt < WINDOWS - 1) begin
				$display("t=%0t layer_finish high before the last window completed",
					$time);
				other_cnt = other_cnt + 1;
			end
			if (ofm_sample) begin
				check_sample();
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus from the pattern file
	////////////////////////////////////////////////////////////

	// Next line that holds data, empty string at end of file
	task automatic read_data_line(output string line);
		string buf_line;
		int    got;
		bit    found;
		line  = "";
		found = 1'b0;
		while (!found && !$feof(fd)) begin
			got = $fgets(buf_line, fd);
			if (got > 0 && buf_line.len() > 1 && buf_line.getc(0) != "#") begin
				line  = buf_line;
				found = 1'b1;
			end
		end
	endtask

	task automatic drive_tap(input data_t value);
		@(negedge clk);
		layer_en = 1'b1;
		ifm      = value;
	endtask

	// Occasional pause, junk on ifm while enable is low
	task automatic insert_gap();
		int len;
		if (gap_left > 0 && ($random(seed) & 32'h7) == 0) begin
			len = 1 + ($random(seed) & 32'h3);
			if (len > gap_left) begin
				len = gap_left;
			end
			gap_left = gap_left - len;
			repeat (len) begin
				@(negedge clk);
				layer_en = 1'b0;
				ifm      = data_t'($random(seed));
			end
		end
	endtask

	task automatic send_layer();
		string line;
		data_t taps [WIN_LEN];
		data_t exp_val [LANES];
		int    got;
		for (int w = 0; w < WINDOWS; w++) begin
			for (int t = 0; t < WIN_LEN; t++) begin
				read_data_line(line);
				got = $sscanf(line, "%h", taps[t]);
				if (got != 1) begin
					$display("pattern file has no tap %0d for window %0d", t, w);
					other_cnt = other_cnt + 1;
				end
			end
			// One expected value per lane on a single line
			read_data_line(line);
			got = $sscanf(line, "%h %h %h %h",
				exp_val[0], exp_val[1], exp_val[2], exp_val[3]);
			if (got != LANES) begin
				$display("pattern file has no expected outputs for window %0d", w);
				other_cnt = other_cnt + 1;
			end
			for (int l = 0; l < LANES; l++) begin
				exp_q.push_back(exp_val[l]);
			end
			for (int t = 0; t < WIN_LEN; t++) begin
				// Window 0 unbroken, later windows may pause
				if (w > 0) begin
					insert_gap();
				end
				drive_tap(taps[t]);
			end
			last_tap_q.push_back(cycle_cnt);
		end
		@(negedge clk);
		layer_en = 1'b0;
		ifm      = '0;
	endtask

	////////////////////////////////////////////////////////////
	// Finish level and RAM feedback
	////////////////////////////////////////////////////////////

	task automatic check_finish();
		while (!layer_finish) begin
			@(negedge clk);
		end
		// Level holds until the RAM answers
		repeat (4) begin
			@(negedge clk);
			if (!layer_finish) begin
				$display("t=%0t layer_finish dropped before ram_feedback", $time);
				other_cnt = other_cnt + 1;
			end
		end
		ram_feedback = 1'b1;
		@(negedge clk);
		ram_feedback = 1'b0;
		repeat (20) begin
			if (layer_finish) begin
				$display("t=%0t layer_finish high after ram_feedback", $time);
				other_cnt = other_cnt + 1;
			end
			@(negedge clk);
		end
		if (sample_cnt != WINDOWS) begin
			$display("saw %0d ofm_sample pulses, a layer has %0d windows",
				sample_cnt, WINDOWS);
			other_cnt = other_cnt + 1;
		end
	endtask

	initial begin
		seed         = 32'hdd60_2e3b;
		rst_n        = 1'b0;
		layer_en     = 1'b0;
		ifm          = '0;
		ram_feedback = 1'b0;
		cycle_cnt    = 0;
		sample_cnt   = 0;
		mismatch_cnt = 0;
		other_cnt    = 0;
		gap_left     = GAP_BUDGET;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		// Quiet outputs straight out of reset
		repeat (2) begin
			@(negedge clk);
			if (ofm_sample || layer_finish) begin
				$display("t=%0t ofm_sample or layer_finish high after reset", $time);
				other_cnt = other_cnt + 1;
			end
		end
		fd = $fopen("dv/squeeze_patterns.txt", "r");
		if (fd == 0) begin
			$display("cannot open dv/squeeze_patterns.txt");
			other_cnt = other_cnt + 1;
		end else begin
			send_layer();
			$fclose(fd);
			check_finish();
		end
		finish_run();
	end

endmodule

`default_nettype wire

//--- dv/squeeze_patterns.txt
# Per window: 18 lines of one hex input tap each, in tap address order
# then one line of 4 hex expected ofm values, lane 0 first
2800
f000
1c00
0c00
e800
3000
1400
2000
f800
2400
0400
e400
2c00
1000
1800
ec00
3400
0800
000a 0000 0001 0000
b000
6400
3800
dc00
b800
5800
f400
c400
4c00
1800
d400
a000
4400
0000
e000
5400
fc00
4000
0005 0000 0020 0000
7800
d800
d000
6c00
2000
c000
1c00
4800
e800
b000
3c00
1400
dc00
e400
3000
f400
f000
7c00
0000 001c 0000 0018
7fff
8000
1000
2400
fc00
0800
5000
cc00
0c00
2800
3800
0000
1800
4800
f800
0400
1400
8800
000a 0000 0000 0004

//--- squeeze_conv_layer.f
design/squeeze_pkg.sv
design/mac_lane.sv
design/weight_rom.sv
design/output_requant.sv
design/window_sequencer.sv
design/squeeze_conv_layer.sv
dv/squeeze_conv_layer_tb.sv
